// ==== common/sha_ctrl_pkg.sv ====
//////////////////////////////
// shared packed struct types of the SHA-256 control block
//////////////////////////////
`default_nettype none
`include "sha_ctrl_settings.svh"

package sha_ctrl_pkg;

  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`SHA_ADDR_W-1:0] adr;
    logic [`SHA_DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                   ack;
    logic [`SHA_DATA_W-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic                   srst;
    logic [`SHA_THLD_W-1:0] thld;
    logic [`SHA_OPC_W-1:0]  opcode;
  } cfg_t;

  // bit order matches the CTL register, init in bit 0
  typedef struct packed {
    logic abort;
    logic last;
    logic init;
  } ctl_t;

  typedef struct packed {
    logic [`SHA_STS_LVL_W-1:0] lvl;
    logic                      busy;
    logic                      derr;
    logic                      rdy;
    logic                      avl;
  } sts_t;

  // same layout as IE[3:0]
  typedef struct packed {
    logic busyie;
    logic derrie;
    logic rdyie;
    logic avlie;
  } ie_t;

  typedef struct packed {
    logic [`SHA_LVL_W-1:0] level;
    logic                  empty;
    logic                  upborder;
    logic                  overflow;
  } fifo_stat_t;

  typedef struct packed {
    logic                   last;
    logic [`SHA_DATA_W-1:0] data;
  } din_beat_t;

endpackage

`default_nettype wire

// ==== common/sha_ctrl_settings.svh ====
//////////////////////////////
// register map, FIFO depth, ID value and widths
// for the SHA-256 control block
//////////////////////////////
`ifndef SHA_CTRL_SETTINGS_SVH
`define SHA_CTRL_SETTINGS_SVH

`define SHA_DATA_W      32
`define SHA_ADDR_W      12
`define SHA_FIFO_DEPTH  4
`define SHA_LVL_W       3
`define SHA_HASH_WORDS  8
`define SHA_THLD_W      5
`define SHA_OPC_W       4
`define SHA_STS_LVL_W   5
`define SHA_ID_VALUE    32'h0001_0002

`define SHA_ADDR_ID     12'h000
`define SHA_ADDR_CFG    12'h010
`define SHA_ADDR_CTL    12'h020
`define SHA_ADDR_STS    12'h030
`define SHA_ADDR_IE     12'h040
`define SHA_ADDR_HASH   12'h100
`define SHA_ADDR_DIN    12'h140

`endif

// ==== rtl/sha_core_feeder.sv ====
//////////////////////////////
// start/valid/last handshake towards the hash core
//////////////////////////////
`default_nettype none
`include "sha_ctrl_settings.svh"

module sha_core_feeder (
  input  logic                     clk_i,
  input  logic                     resetn_i,
  input  logic [`SHA_DATA_W-1:0]   head_i,
  input  sha_ctrl_pkg::fifo_stat_t stat_i,
  input  sha_ctrl_pkg::cfg_t       cfg_i,
  input  sha_ctrl_pkg::ctl_t       ctl_i,
  input  logic                     ready_i,
  input  logic                     core_ready_i,
  output sha_ctrl_pkg::din_beat_t  beat_o,
  output logic                     valid_o,
  output logic                     start_o,
  output logic                     pop_o,
  output logic                     init_ack_o,
  output logic                     last_ack_o,
  output logic [`SHA_OPC_W-1:0]    opcode_o,
  output logic                     abort_o
);

  logic xfer;
  logic kick;

  assign xfer = valid_o & ready_i;
  // words go out once a message is opened or the core is already running
  assign kick = ~stat_i.empty & (start_o | ctl_i.init | ~core_ready_i);

  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      start_o <= 1'b0;
      valid_o <= 1'b0;
    end else if (cfg_i.srst | ctl_i.abort) begin
      start_o <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      if (start_o & xfer)
        start_o <= 1'b0;
      else if (ctl_i.init & core_ready_i)
        start_o <= 1'b1;
      // valid holds until taken, drops when the FIFO runs dry
      if (xfer)
        valid_o <= stat_i.level > `SHA_LVL_W'(1);
      else if (!valid_o)
        valid_o <= kick;
    end
  end

  // last tags the final word in the FIFO while CTL.last is set
  assign beat_o = '{
    last: valid_o & ctl_i.last & (stat_i.level == `SHA_LVL_W'(1)),
    data: head_i
  };

  assign pop_o      = xfer;
  assign init_ack_o = ctl_i.init & start_o;
  assign last_ack_o = xfer & beat_o.last;
  assign opcode_o   = cfg_i.opcode;
  assign abort_o    = ctl_i.abort;

endmodule

`default_nettype wire

// ==== rtl/sha_ctrl_top.sv ====
//////////////////////////////
// top level of the SHA-256 control block
// register block, input FIFO and core feeder
//////////////////////////////
`default_nettype none
`include "sha_ctrl_settings.svh"

module sha_ctrl_top (
  input  logic                                   clk_i,
  input  logic                                   resetn_i,
  input  sha_ctrl_pkg::wb_req_t                  wb_req_i,
  output sha_ctrl_pkg::wb_rsp_t                  wb_rsp_o,
  output logic [`SHA_DATA_W-1:0]                 data_o,
  output logic                                   valid_o,
  output logic                                   last_o,
  output logic                                   start_o,
  output logic [`SHA_OPC_W-1:0]                  opcode_o,
  output logic                                   abort_o,
  input  logic                                   ready_i,
  input  logic                                   core_ready_i,
  input  logic                                   done_i,
  input  logic [`SHA_HASH_WORDS*`SHA_DATA_W-1:0] hash_i,
  output logic                                   irq_o
);

  logic                     push;
  logic [`SHA_DATA_W-1:0]   push_data;
  logic [`SHA_DATA_W-1:0]   head;
  logic                     pop;
  logic                     init_ack;
  logic                     last_ack;
  sha_ctrl_pkg::cfg_t       cfg;
  sha_ctrl_pkg::ctl_t       ctl;
  sha_ctrl_pkg::fifo_stat_t fifo_stat;
  sha_ctrl_pkg::din_beat_t  beat;

  sha_csr_regs u_csr (
    .clk_i        (clk_i),
    .resetn_i     (resetn_i),
    .wb_req_i     (wb_req_i),
    .core_ready_i (core_ready_i),
    .done_i       (done_i),
    .hash_i       (hash_i),
    .fifo_stat_i  (fifo_stat),
    .init_ack_i   (init_ack),
    .last_ack_i   (last_ack),
    .wb_rsp_o     (wb_rsp_o),
    .push_o       (push),
    .push_data_o  (push_data),
    .cfg_o        (cfg),
    .ctl_o        (ctl),
    .irq_o        (irq_o)
  );

  sha_din_fifo u_fifo (
    .clk_i       (clk_i),
    .resetn_i    (resetn_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .cfg_i       (cfg),
    .ctl_i       (ctl),
    .head_o      (head),
    .stat_o      (fifo_stat)
  );

  sha_core_feeder u_feeder (
    .clk_i        (clk_i),
    .resetn_i     (resetn_i),
    .head_i       (head),
    .stat_i       (fifo_stat),
    .cfg_i        (cfg),
    .ctl_i        (ctl),
    .ready_i      (ready_i),
    .core_ready_i (core_ready_i),
    .beat_o       (beat),
    .valid_o      (valid_o),
    .start_o      (start_o),
    .pop_o        (pop),
    .init_ack_o   (init_ack),
    .last_ack_o   (last_ack),
    .opcode_o     (opcode_o),
    .abort_o      (abort_o)
  );

  assign data_o = beat.data;
  assign last_o = beat.last;

endmodule

`default_nettype wire

// ==== rtl/sha_din_fifo.sv ====
//////////////////////////////
// input FIFO with level, threshold and full detection
//////////////////////////////
`default_nettype none
`include "sha_ctrl_settings.svh"

module sha_din_fifo (
  input  logic                     clk_i,
  input  logic                     resetn_i,
  input  logic                     push_i,
  input  logic [`SHA_DATA_W-1:0]   push_data_i,
  input  logic                     pop_i,
  input  sha_ctrl_pkg::cfg_t       cfg_i,
  input  sha_ctrl_pkg::ctl_t       ctl_i,
  output logic [`SHA_DATA_W-1:0]   head_o,
  output sha_ctrl_pkg::fifo_stat_t stat_o
);

  localparam int PTR_W = $clog2(`SHA_FIFO_DEPTH);

  logic [`SHA_DATA_W-1:0] mem [`SHA_FIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [`SHA_LVL_W-1:0]  level;
  logic                   full;
  logic                   empty;
  logic                   wr_en;
  logic                   rd_en;
  logic                   flush;

  assign full  = level == `SHA_LVL_W'(`SHA_FIFO_DEPTH);
  assign empty = level == '0;
  // push while full is ignored here, the register block flags it
  assign wr_en = push_i & ~full;
  assign rd_en = pop_i & ~empty;
  assign flush = cfg_i.srst | ctl_i.abort;

  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      // depth is a power of two, so the pointers wrap by themselves
      wr_ptr <= wr_ptr + PTR_W'(wr_en);
      rd_ptr <= rd_ptr + PTR_W'(rd_en);
      level  <= level + `SHA_LVL_W'(wr_en) - `SHA_LVL_W'(rd_en);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en)
      mem[wr_ptr] <= push_data_i;
  end

  assign head_o = mem[rd_ptr];

  assign stat_o = '{
    level:    level,
    empty:    empty,
    upborder: `SHA_THLD_W'(level) >= cfg_i.thld,
    overflow: full
  };

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the SHA control testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module sha_ctrl_tb -Mdir obj_dir -o sha_ctrl_sim -f vlog.f
./obj_dir/sha_ctrl_sim > sim.log 2>&1
cat sim.log
if grep -qF '*** TEST FAILED ***' sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

// ==== sha_csr/sha_csr_regs.sv ====
//////////////////////////////
// Wishbone classic slave with register file,
// status flags, hash capture and interrupt
//////////////////////////////
`default_nettype none
`include "sha_ctrl_settings.svh"

module sha_csr_regs (
  input  logic                                   clk_i,
  input  logic                                   resetn_i,
  input  sha_ctrl_pkg::wb_req_t                  wb_req_i,
  input  logic                                   core_ready_i,
  input  logic                                   done_i,
  input  logic [`SHA_HASH_WORDS*`SHA_DATA_W-1:0] hash_i,
  input  sha_ctrl_pkg::fifo_stat_t               fifo_stat_i,
  input  logic                                   init_ack_i,
  input  logic                                   last_ack_i,
  output sha_ctrl_pkg::wb_rsp_t                  wb_rsp_o,
  output logic                                   push_o,
  output logic [`SHA_DATA_W-1:0]                 push_data_o,
  output sha_ctrl_pkg::cfg_t                     cfg_o,
  output sha_ctrl_pkg::ctl_t                     ctl_o,
  output logic                                   irq_o
);

  localparam int HIDX_W = $clog2(`SHA_HASH_WORDS);
  localparam logic [`SHA_ADDR_W-1:0] HASH_BASE = `SHA_ADDR_HASH;
  localparam logic [`SHA_ADDR_W-1:0] DIN_BASE = `SHA_ADDR_DIN;

  logic                                              ack_q;
  logic [`SHA_DATA_W-1:0]                            rdata_q;
  logic [`SHA_DATA_W-1:0]                            rd_mux;
  logic [`SHA_ADDR_W-1:0]                            word_adr;
  logic                                              req_seen;
  logic                                              wr_req;
  logic                                              rd_req;
  logic                                              din_hit;
  logic                                              hash_hit;
  logic [HIDX_W-1:0]                                 hash_idx;
  logic [`SHA_HASH_WORDS-1:0][`SHA_DATA_W-1:0]       hash_q;
  sha_ctrl_pkg::cfg_t                                cfg_q;
  sha_ctrl_pkg::ctl_t                                ctl_q;
  sha_ctrl_pkg::ie_t                                 ie_q;
  sha_ctrl_pkg::sts_t                                sts;
  logic                                              avl_q;
  logic                                              rdy_q;
  logic                                              derr_q;
  logic                                              busy_q;

  // a request held by the master is taken once, ack blocks the repeat
  assign req_seen = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign wr_req   = req_seen & wb_req_i.we;
  assign rd_req   = req_seen & ~wb_req_i.we;
  assign word_adr = {wb_req_i.adr[`SHA_ADDR_W-1:2], 2'b00};
  assign din_hit  = word_adr[`SHA_ADDR_W-1:4] == DIN_BASE[`SHA_ADDR_W-1:4];
  assign hash_hit = word_adr[`SHA_ADDR_W-1:HIDX_W+2] == HASH_BASE[`SHA_ADDR_W-1:HIDX_W+2];
  assign hash_idx = word_adr[HIDX_W+1:2];

  assign sts = '{
    lvl:  `SHA_STS_LVL_W'(fifo_stat_i.level),
    busy: busy_q,
    derr: derr_q,
    rdy:  rdy_q,
    avl:  avl_q
  };

  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      ack_q  <= 1'b0;
      push_o <= 1'b0;
    end else begin
      ack_q  <= req_seen;
      push_o <= wr_req & din_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_req & din_hit)
      push_data_o <= wb_req_i.dat;
    if (rd_req)
      rdata_q <= rd_mux;
  end

  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      cfg_q  <= '0;
      ctl_q  <= '0;
      ie_q   <= '0;
      avl_q  <= 1'b0;
      rdy_q  <= 1'b1;
      derr_q <= 1'b0;
      busy_q <= 1'b0;
    end else if (cfg_q.srst) begin
      cfg_q  <= '0;
      ctl_q  <= '0;
      ie_q   <= '0;
      avl_q  <= 1'b0;
      rdy_q  <= 1'b1;
      derr_q <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      busy_q <= ~core_ready_i;
      if (done_i)
        avl_q <= 1'b1;
      else if (rd_req && word_adr == HASH_BASE)
        avl_q <= 1'b0;
      if (fifo_stat_i.empty)
        rdy_q <= 1'b1;
      else if (fifo_stat_i.upborder | fifo_stat_i.overflow)
        rdy_q <= 1'b0;
      // a push into a full FIFO is lost
      if (push_o & fifo_stat_i.overflow)
        derr_q <= 1'b1;
      else if (rd_req && word_adr == `SHA_ADDR_STS)
        derr_q <= 1'b0;
      // abort lives for one cycle only
      ctl_q.abort <= 1'b0;
      if (init_ack_i)
        ctl_q.init <= 1'b0;
      if (last_ack_i)
        ctl_q.last <= 1'b0;
      if (wr_req) begin
        case (word_adr)
          `SHA_ADDR_CFG: begin
            cfg_q <= '{
              srst:   wb_req_i.dat[31],
              thld:   wb_req_i.dat[12:8],
              opcode: wb_req_i.dat[3:0]
            };
          end
          `SHA_ADDR_CTL: begin
            ctl_q.abort <= wb_req_i.dat[2];
            ctl_q.last  <= wb_req_i.dat[1];
            if (wb_req_i.dat[0])
              ctl_q.init <= 1'b1;
          end
          `SHA_ADDR_IE: ie_q <= wb_req_i.dat[3:0];
          default: ;
        endcase
      end
    end
  end

  // hash result, word i at bits 32i
  always_ff @(posedge clk_i) begin
    if (cfg_q.srst)
      hash_q <= '0;
    else if (done_i)
      hash_q <= hash_i;
  end

  always_comb begin
    rd_mux = '0;
    case (word_adr)
      `SHA_ADDR_ID:  rd_mux = `SHA_ID_VALUE;
      `SHA_ADDR_CFG: begin
        rd_mux[31]   = cfg_q.srst;
        rd_mux[12:8] = cfg_q.thld;
        rd_mux[3:0]  = cfg_q.opcode;
      end
      `SHA_ADDR_CTL: rd_mux[2:0] = ctl_q;
      `SHA_ADDR_STS: begin
        rd_mux[12:8] = sts.lvl;
        rd_mux[3:0]  = {sts.busy, sts.derr, sts.rdy, sts.avl};
      end
      `SHA_ADDR_IE:  rd_mux[3:0] = ie_q;
      default: begin
        if (hash_hit)
          rd_mux = hash_q[hash_idx];
      end
    endcase
  end

  assign wb_rsp_o = '{ack: ack_q, dat: rdata_q};
  assign cfg_o    = cfg_q;
  assign ctl_o    = ctl_q;
  assign irq_o    = |({sts.busy, sts.derr, sts.rdy, sts.avl} & ie_q);

endmodule

`default_nettype wire

// ==== verif/sha_ctrl_props.sv ====
//////////////////////////////
// bus and core handshake assertions
//////////////////////////////
`default_nettype none
`include "sha_ctrl_settings.svh"

module sha_ctrl_props (
  input logic                   clk_i,
  input logic                   resetn_i,
  input sha_ctrl_pkg::wb_rsp_t  wb_rsp_i,
  input logic                   valid_i,
  input logic                   ready_i,
  input logic                   last_i,
  input logic [`SHA_DATA_W-1:0] data_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // ack is a single-cycle pulse
  ack_pulse: assert property (@(posedge clk_i) disable iff (!resetn_i)
    wb_rsp_i.ack |=> !wb_rsp_i.ack)
    else $error("ack stayed high for more than one cycle");

  // back-pressure keeps the word in place
  valid_hold: assert property (@(posedge clk_i) disable iff (!resetn_i)
    valid_i && !ready_i |=> valid_i && $stable(data_i))
    else $error("valid or data changed while ready was low");

  // last stays on the word until the core takes it
  last_hold: assert property (@(posedge clk_i) disable iff (!resetn_i)
    last_i && !ready_i |=> last_i && valid_i)
    else $error("last dropped while ready was low");

endmodule

bind sha_ctrl_top sha_ctrl_props i_props (
  .clk_i    (clk_i),
  .resetn_i (resetn_i),
  .wb_rsp_i (wb_rsp_o),
  .valid_i  (valid_o),
  .ready_i  (ready_i),
  .last_i   (last_o),
  .data_i   (data_o)
);

`default_nettype wire

// ==== verif/sha_ctrl_tb.sv ====
//////////////////////////////
// testbench with core model, bus tasks,
// reference hash, checks and timeout
//////////////////////////////
`default_nettype none
`include "sha_ctrl_settings.svh"

module sha_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // about 50 bus accesses of 4 cycles plus ready stalls, with wide margin
  localparam int MAX_CYCLES = 4000;
  localparam int MSG_WORDS  = 4;

  typedef struct packed {
    logic                   start;
    logic                   last;
    logic [`SHA_DATA_W-1:0] data;
  } rx_beat_t;

  logic                                   clk_i;
  logic                                   resetn_i;
  sha_ctrl_pkg::wb_req_t                  wb_req;
  sha_ctrl_pkg::wb_rsp_t                  wb_rsp;
  logic [`SHA_DATA_W-1:0]                 data;
  logic                                   valid;
  logic                                   last;
  logic                                   start;
  logic [`SHA_OPC_W-1:0]                  opcode;
  logic                                   abort;
  logic                                   ready      = 1'b0;
  logic                                   core_ready = 1'b1;
  logic                                   done       = 1'b0;
  logic [`SHA_HASH_WORDS*`SHA_DATA_W-1:0] hash       = '0;
  logic                                   irq;

  int unsigned            errors     = 0;
  int unsigned            abort_cnt  = 0;
  logic [31:0]            data_seed  = 32'hba1b;
  // second stream for the ready stalls
  logic [31:0]            stall_seed = ~32'hba1b;
  logic                   hold_ready = 1'b0;
  logic                   msg_done   = 1'b0;
  logic [31:0]            rx_xor     = '0;
  logic [31:0]            exp_xor    = '0;
  logic [3:0]             ie_val     = '0;
  logic [31:0]            exp_q [$];
  rx_beat_t               rx_q [$];

  sha_ctrl_top i_sha_ctrl_top (
    .clk_i        (clk_i),
    .resetn_i     (resetn_i),
    .wb_req_i     (wb_req),
    .wb_rsp_o     (wb_rsp),
    .data_o       (data),
    .valid_o      (valid),
    .last_o       (last),
    .start_o      (start),
    .opcode_o     (opcode),
    .abort_o      (abort),
    .ready_i      (ready),
    .core_ready_i (core_ready),
    .done_i       (done),
    .hash_i       (hash),
    .irq_o        (irq)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // hash word i is the XOR of all message words, rotated left by i
  function automatic logic [255:0] ref_hash(input logic [31:0] x);
    logic [255:0] h;
    h = '0;
    for (int i = 0; i < `SHA_HASH_WORDS; i++)
      h[i*32 +: 32] = (x << i) | (x >> (32 - i));
    return h;
  endfunction

  function automatic logic [31:0] sts_value(input logic [4:0] lvl, input logic [3:0] flags);
    return {19'b0, lvl, 4'b0, flags};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic draw(output logic [31:0] v);
    data_seed = lcg_next(data_seed);
    v = data_seed;
  endtask

  task automatic set_hold(input logic v);
    @(negedge clk_i);
    hold_ready = v;
  endtask

  task automatic wb_access(input logic we, input logic [`SHA_ADDR_W-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    @(posedge clk_i);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    @(negedge clk_i);
    while (!wb_rsp.ack)
      @(negedge clk_i);
    rdat = wb_rsp.dat;
    @(posedge clk_i);
    wb_req <= '0;
  endtask

  task automatic wb_write(input logic [`SHA_ADDR_W-1:0] adr, input logic [31:0] wdat);
    logic [31:0] unused_rdat;
    wb_access(1'b1, adr, wdat, unused_rdat);
  endtask

  task automatic wb_read(input logic [`SHA_ADDR_W-1:0] adr, output logic [31:0] rdat);
    wb_access(1'b0, adr, '0, rdat);
  endtask

  task automatic check_irq(input string name, input logic [3:0] flags);
    @(negedge clk_i);
    check_value(name, 32'(|(flags & ie_val)), 32'(irq));
  endtask

  // core model, busy from the start word until done
  always @(posedge clk_i) begin
    if (resetn_i) begin
      done <= 1'b0;
      if (abort)
        abort_cnt++;
      if (msg_done) begin
        done       <= 1'b1;
        hash       <= ref_hash(rx_xor);
        core_ready <= 1'b1;
        msg_done = 1'b0;
      end
      if (valid && ready) begin
        rx_q.push_back({start, last, data});
        rx_xor = rx_xor ^ data;
        if (start)
          core_ready <= 1'b0;
        if (last)
          msg_done = 1'b1;
      end
      stall_seed = lcg_next(stall_seed);
      ready <= hold_ready ? 1'b0 : stall_seed[16];
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: tests did not finish in %0d cycles, errors: %0d", MAX_CYCLES, errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    logic [31:0]  v;
    logic [31:0]  w;
    logic [255:0] h;
    wb_req   = '0;
    resetn_i = 1'b0;
    repeat (8) @(posedge clk_i);
    resetn_i <= 1'b1;

    // ID, then CFG and IE readback
    wb_read(`SHA_ADDR_ID, v);
    check_value("id", `SHA_ID_VALUE, v);
    draw(w);
    w[31] = 1'b0;
    wb_write(`SHA_ADDR_CFG, w);
    wb_read(`SHA_ADDR_CFG, v);
    check_value("cfg readback", w & 32'h0000_1f0f, v);
    check_value("opcode", 32'(w[3:0]), 32'(opcode));
    draw(w);
    wb_write(`SHA_ADDR_IE, w);
    wb_read(`SHA_ADDR_IE, v);
    check_value("ie readback", w & 32'h0000_000f, v);

    // one message of four words, core stalled until all are queued
    ie_val = 4'b0001;
    wb_write(`SHA_ADDR_IE, 32'(ie_val));
    set_hold(1'b1);
    wb_write(`SHA_ADDR_CTL, 32'h1);
    for (int i = 0; i < MSG_WORDS; i++) begin
      draw(w);
      exp_q.push_back(w);
      exp_xor = exp_xor ^ w;
      wb_write(`SHA_ADDR_DIN + 12'(4 * i), w);
    end
    wb_write(`SHA_ADDR_CTL, 32'h2);
    set_hold(1'b0);

    // wait for avl, then hash readback
    v = '0;
    while (!v[0])
      wb_read(`SHA_ADDR_STS, v);
    check_value("sts on avl", sts_value(5'd0, 4'b0011), v);
    check_irq("irq on avl", 4'b0011);
    check_value("words received", 32'(MSG_WORDS), 32'(rx_q.size()));
    if (rx_q.size() == MSG_WORDS) begin
      for (int i = 0; i < MSG_WORDS; i++) begin
        check_value($sformatf("core word %0d", i), exp_q[i], rx_q[i].data);
        check_value($sformatf("start on word %0d", i), 32'(i == 0), 32'(rx_q[i].start));
        check_value($sformatf("last on word %0d", i), 32'(i == MSG_WORDS - 1),
                    32'(rx_q[i].last));
      end
    end
    h = ref_hash(exp_xor);
    for (int i = 0; i < `SHA_HASH_WORDS; i++) begin
      wb_read(`SHA_ADDR_HASH + 12'(4 * i), v);
      check_value($sformatf("hash word %0d", i), h[i*32 +: 32], v);
    end
    wb_read(`SHA_ADDR_STS, v);
    check_value("sts after hash read", sts_value(5'd0, 4'b0010), v);
    check_irq("irq after hash read", 4'b0010);

    // overflow with the core stalled
    ie_val = 4'b0100;
    wb_write(`SHA_ADDR_IE, 32'(ie_val));
    set_hold(1'b1);
    for (int i = 0; i <= `SHA_FIFO_DEPTH; i++) begin
      draw(w);
      wb_write(`SHA_ADDR_DIN, w);
    end
    check_irq("irq on derr", 4'b0100);
    wb_read(`SHA_ADDR_STS, v);
    check_value("sts on overflow", sts_value(5'd4, 4'b0100), v);
    wb_read(`SHA_ADDR_STS, v);
    check_value("sts after derr read", sts_value(5'd4, 4'b0000), v);
    check_irq("irq after derr read", 4'b0000);

    // soft reset, with a pending last in CTL
    wb_write(`SHA_ADDR_CTL, 32'h2);
    wb_write(`SHA_ADDR_CFG, 32'h8000_0000);
    ie_val = 4'b0000;
    wb_read(`SHA_ADDR_CFG, v);
    check_value("cfg after srst", 32'h0, v);
    wb_read(`SHA_ADDR_CTL, v);
    check_value("ctl after srst", 32'h0, v);
    wb_read(`SHA_ADDR_IE, v);
    check_value("ie after srst", 32'h0, v);
    wb_read(`SHA_ADDR_STS, v);
    check_value("sts after srst", sts_value(5'd0, 4'b0010), v);
    check_irq("irq after srst", 4'b0010);

    // abort empties the FIFO and pulses abort_o once
    draw(w);
    wb_write(`SHA_ADDR_DIN, w);
    wb_read(`SHA_ADDR_STS, v);
    check_value("sts before abort", sts_value(5'd1, 4'b0000), v);
    wb_write(`SHA_ADDR_CTL, 32'h4);
    wb_read(`SHA_ADDR_STS, v);
    check_value("sts after abort", sts_value(5'd0, 4'b0010), v);
    check_value("abort pulse cycles", 32'd1, 32'(abort_cnt));
    set_hold(1'b0);

    $display("checks done, errors: %0d", errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/sha_ctrl_pkg.sv
rtl/sha_din_fifo.sv
rtl/sha_core_feeder.sv
sha_csr/sha_csr_regs.sv
rtl/sha_ctrl_top.sv
verif/sha_ctrl_props.sv
verif/sha_ctrl_tb.sv
